/* verilog/cpu_pkg.sv */
//----------------------------------------------------------------------
// Subset 6502 types, binary arithmetic only (D is stored, never used)
//----------------------------------------------------------------------
package cpu_pkg;

  //----------------------------------------------------------------------
  // Opcodes, real 6502 encodings
  //----------------------------------------------------------------------
  localparam logic [7:0] LDA_IMM = 8'hA9;
  localparam logic [7:0] LDA_ABS = 8'hAD;
  localparam logic [7:0] ADC_IMM = 8'h69;
  localparam logic [7:0] ADC_ABS = 8'h6D;
  localparam logic [7:0] AND_IMM = 8'h29;
  localparam logic [7:0] AND_ABS = 8'h2D;
  localparam logic [7:0] ORA_IMM = 8'h09;
  localparam logic [7:0] ORA_ABS = 8'h0D;
  localparam logic [7:0] STA_ABS = 8'h8D;
  localparam logic [7:0] JMP_ABS = 8'h4C;
  localparam logic [7:0] NOP     = 8'hEA;

  // Status register bit positions
  localparam int ST_N = 7;
  localparam int ST_V = 6;
  localparam int ST_U = 5;   // Reads as one
  localparam int ST_B = 4;
  localparam int ST_D = 3;
  localparam int ST_I = 2;
  localparam int ST_Z = 1;
  localparam int ST_C = 0;

  // Reset vector, little endian
  localparam logic [15:0] RESET_LO = 16'hFFFC;
  localparam logic [15:0] RESET_HI = 16'hFFFD;

  typedef enum logic [1:0] {
    ALU_SUM  = 2'b00,   // A + B + C
    ALU_AND  = 2'b01,
    ALU_OR   = 2'b10,
    ALU_PASS = 2'b11    // B straight through, used by LDA
  } alu_op_t;

  typedef enum logic [1:0] {
    MODE_IMPL    = 2'b00,   // Opcode only
    MODE_IMM     = 2'b01,   // Opcode + data byte
    MODE_ABS     = 2'b10,   // Opcode + 16-bit address
    MODE_ILLEGAL = 2'b11
  } addr_mode_t;

  //----------------------------------------------------------------------
  // Shared records
  //----------------------------------------------------------------------
  typedef struct packed {
    addr_mode_t mode;
    alu_op_t    alu_op;
    logic       store;      // STA
    logic       jump;       // JMP
    logic       writes_a;
    logic       sets_cv;    // ADC only
  } dec_t;

  typedef struct packed {
    alu_op_t    op;
    logic [7:0] a;
    logic [7:0] b;
    logic       carry_in;
  } alu_req_t;

  typedef struct packed {
    logic [7:0] y;
    logic       n;
    logic       z;
    logic       c;
    logic       v;
  } alu_res_t;

  typedef struct packed {
    logic     valid;
    alu_res_t res;
    logic     sets_cv;
    logic     writes_a;
  } wb_t;

endpackage

/* verilog/cpu_alu.sv */
//----------------------------------------------------------------------
// Binary ALU, result registered one cycle after the request
//----------------------------------------------------------------------
`timescale 1ns/1ns

module cpu_alu
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     resetn,
  input  alu_req_t req,
  output alu_res_t res
);

  logic [8:0] sum;     // Ninth bit is carry out
  alu_res_t   nxt;

  always_comb begin
    sum   = {1'b0, req.a} + {1'b0, req.b} + {8'd0, req.carry_in};
    nxt   = '0;
    nxt.c = req.carry_in;   // Logical ops keep C
    nxt.v = 1'b0;           // Ignored unless sets_cv
    case (req.op)
      ALU_SUM: begin
        nxt.y = sum[7:0];
        nxt.c = sum[8];
        // Signed overflow: like-signed inputs, result sign differs
        nxt.v = (req.a[7] == req.b[7]) && (sum[7] != req.a[7]);
      end
      ALU_AND: nxt.y = req.a & req.b;
      ALU_OR:  nxt.y = req.a | req.b;
      default: nxt.y = req.b;   // PASS
    endcase
    nxt.n = nxt.y[7];
    nxt.z = (nxt.y == 8'h00);
  end

  // Lines up with the write-back slot in FETCH
  always_ff @(posedge clk) begin
    res <= nxt;
  end

  // Sequencer never presents an unknown or undefined operation
  a_op_legal: assert property (@(posedge clk) disable iff (!resetn)
    req.op inside {ALU_SUM, ALU_AND, ALU_OR, ALU_PASS});

endmodule

/* verilog/cpu_decoder.sv */
//----------------------------------------------------------------------
// Opcode decode, combinational; unknown opcodes give MODE_ILLEGAL
//----------------------------------------------------------------------
`timescale 1ns/1ns

module cpu_decoder
  import cpu_pkg::*;
(
  input  logic [7:0] ir,
  output dec_t       dec
);

  //----------------------------------------------------------------------
  // Addressing mode, sets the instruction length
  //----------------------------------------------------------------------
  always_comb begin
    dec      = '0;
    dec.mode = MODE_ILLEGAL;   // Default sends the sequencer to HALT
    case (ir)
      NOP: dec.mode = MODE_IMPL;
      LDA_IMM, ADC_IMM, AND_IMM, ORA_IMM: dec.mode = MODE_IMM;
      LDA_ABS, ADC_ABS, AND_ABS, ORA_ABS,
      STA_ABS, JMP_ABS: dec.mode = MODE_ABS;
      default: dec.mode = MODE_ILLEGAL;
    endcase

    // Operation and destination
    dec.alu_op = ALU_PASS;
    case (ir)
      LDA_IMM, LDA_ABS: begin
        dec.alu_op   = ALU_PASS;
        dec.writes_a = 1'b1;
      end
      ADC_IMM, ADC_ABS: begin
        dec.alu_op   = ALU_SUM;
        dec.writes_a = 1'b1;
        dec.sets_cv  = 1'b1;
      end
      AND_IMM, AND_ABS: begin
        dec.alu_op   = ALU_AND;
        dec.writes_a = 1'b1;
      end
      ORA_IMM, ORA_ABS: begin
        dec.alu_op   = ALU_OR;
        dec.writes_a = 1'b1;
      end
      STA_ABS: dec.store = 1'b1;   // A goes out on the bus
      JMP_ABS: dec.jump  = 1'b1;   // Operand becomes PC
      default: dec.alu_op = ALU_PASS;
    endcase
  end

endmodule

/* verilog/cpu_regfile.sv */
//----------------------------------------------------------------------
// A and P registers; B, D and I stay at reset value
//----------------------------------------------------------------------
`timescale 1ns/1ns

module cpu_regfile
  import cpu_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  wb_t        wb,
  output logic [7:0] acc,
  output logic [7:0] status
);

  // Write-back lands on the edge that ends FETCH
  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc    <= 8'h00;
      status <= 8'h20;   // Only U set
    end else if (wb.valid) begin
      if (wb.writes_a) begin
        acc <= wb.res.y;
      end
      // N and Z follow every ALU result
      status[ST_N] <= wb.res.n;
      status[ST_Z] <= wb.res.z;
      if (wb.sets_cv) begin   // Carry chain for ADC
        status[ST_C] <= wb.res.c;
        status[ST_V] <= wb.res.v;
      end
    end
  end

  // U survives reset and every write-back
  a_u_set: assert property (@(posedge clk) disable iff (!resetn)
    status[ST_U]);

endmodule

/* verilog/cpu_control.sv */
//----------------------------------------------------------------------
// One-hot sequencer; one instruction at a time, halts on bad opcode
//----------------------------------------------------------------------
`timescale 1ns/1ns

module cpu_control
  import cpu_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  logic [7:0]  rd_data,
  output logic [15:0] address,
  output logic [7:0]  wr_data,
  output logic        wr_en,
  output logic        sync,
  input  dec_t        dec,
  output logic [7:0]  ir,
  output alu_req_t    alu_req,
  input  alu_res_t    alu_res,
  output wb_t         wb,
  input  logic [7:0]  acc,
  input  logic [7:0]  status
);

  // State bit indices
  localparam int RESET    = 0;
  localparam int VECTOR_1 = 1;
  localparam int VECTOR_2 = 2;
  localparam int FETCH    = 3;
  localparam int DECODE   = 4;
  localparam int ABS_1    = 5;
  localparam int ABS_2    = 6;
  localparam int HALT     = 7;

  logic [7:0]  state;
  logic [7:0]  next;
  logic [15:0] pc;
  logic [15:0] pc_nxt;
  logic [15:0] addr_nxt;
  logic [7:0]  op_lo;        // Operand low byte
  logic        issue;        // ALU request valid this cycle
  logic        wb_pending;
  logic        wb_a;
  logic        wb_cv;

  //----------------------------------------------------------------------
  // Next state, PC and bus address
  //----------------------------------------------------------------------
  always_comb begin
    next     = '0;
    pc_nxt   = pc;
    addr_nxt = address;
    case (1'b1)
      state[RESET]: begin
        next[VECTOR_1] = 1'b1;
        addr_nxt       = RESET_LO;
      end
      state[VECTOR_1]: begin
        next[VECTOR_2] = 1'b1;
        pc_nxt         = {pc[15:8], rd_data};   // Vector low byte
        addr_nxt       = RESET_HI;
      end
      state[VECTOR_2]: begin
        next[FETCH] = 1'b1;
        pc_nxt      = {rd_data, pc[7:0]};
        addr_nxt    = {rd_data, pc[7:0]};
      end
      state[FETCH]: begin
        next[DECODE] = 1'b1;
        addr_nxt     = pc + 16'd1;
      end
      state[DECODE]: begin
        case (dec.mode)
          MODE_IMPL: begin
            next[FETCH] = 1'b1;
            pc_nxt      = pc + 16'd1;
            addr_nxt    = pc + 16'd1;
          end
          MODE_IMM: begin   // Operand is on rd_data now
            next[FETCH] = 1'b1;
            pc_nxt      = pc + 16'd2;
            addr_nxt    = pc + 16'd2;
          end
          MODE_ABS: begin
            next[ABS_1] = 1'b1;
            addr_nxt    = pc + 16'd2;
          end
          default: next[HALT] = 1'b1;
        endcase
      end
      state[ABS_1]: begin
        if (dec.jump) begin
          next[FETCH] = 1'b1;
          pc_nxt      = {rd_data, op_lo};
          addr_nxt    = {rd_data, op_lo};
        end else begin
          next[ABS_2] = 1'b1;
          pc_nxt      = pc + 16'd3;
          addr_nxt    = {rd_data, op_lo};   // Data cycle address
        end
      end
      state[ABS_2]: begin
        next[FETCH] = 1'b1;
        addr_nxt    = pc;
      end
      default: next[HALT] = 1'b1;   // HALT holds, bus frozen
    endcase
  end

  // Immediate issues in DECODE, absolute loads in ABS_2
  assign issue = (state[DECODE] && dec.mode == MODE_IMM) ||
                 (state[ABS_2] && !dec.store);

  always_comb begin
    alu_req.op       = dec.alu_op;
    alu_req.a        = acc;
    alu_req.b        = rd_data;
    alu_req.carry_in = status[ST_C];
  end

  // Deferred write-back, presented in the next FETCH
  always_comb begin
    wb.valid    = state[FETCH] && wb_pending;
    wb.res      = alu_res;
    wb.sets_cv  = wb_cv;
    wb.writes_a = wb_a;
  end

  //----------------------------------------------------------------------
  // Control registers
  //----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state      <= 8'b1 << RESET;
      address    <= RESET_LO;
      sync       <= 1'b0;
      wr_en      <= 1'b0;
      wb_pending <= 1'b0;
    end else begin
      state   <= next;
      address <= addr_nxt;
      sync    <= next[FETCH];   // Opcode read cycle
      wr_en   <= state[ABS_1] && dec.store && !dec.jump;
      if (issue) begin
        wb_pending <= 1'b1;
      end else if (state[FETCH]) begin
        wb_pending <= 1'b0;
      end
    end
  end

  // Datapath registers
  always_ff @(posedge clk) begin
    pc <= pc_nxt;
    if (state[FETCH]) ir <= rd_data;
    if (state[DECODE]) op_lo <= rd_data;
    if (state[ABS_1]) wr_data <= acc;   // A already holds prior result
    if (issue) begin
      wb_a  <= dec.writes_a;
      wb_cv <= dec.sets_cv;
    end
  end

  a_state_onehot: assert property (@(posedge clk) disable iff (!resetn)
    $onehot(state));

  // Store strobe only in the STA data cycle
  a_wr_en_abs2: assert property (@(posedge clk) disable iff (!resetn)
    wr_en |-> state[ABS_2] && dec.store);

  // Write-back always follows an ALU request by one cycle
  a_wb_align: assert property (@(posedge clk) disable iff (!resetn)
    wb.valid |-> $past(issue));

endmodule

/* verilog/cpu_top.sv */
//----------------------------------------------------------------------
// 6502 subset core; async-read byte memory, single-cycle write strobe
//----------------------------------------------------------------------
`timescale 1ns/1ns

module cpu_top
  import cpu_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  logic [7:0]  rd_data,   // Byte at address, same cycle
  output logic [15:0] address,
  output logic [7:0]  wr_data,
  output logic        wr_en,
  output logic        sync       // Opcode fetch
);

  logic [7:0] ir;
  dec_t       dec;
  alu_req_t   alu_req;
  alu_res_t   alu_res;
  wb_t        wb;
  logic [7:0] acc;
  logic [7:0] status;

  cpu_control u_control (
    .clk     (clk),
    .resetn  (resetn),
    .rd_data (rd_data),
    .address (address),
    .wr_data (wr_data),
    .wr_en   (wr_en),
    .sync    (sync),
    .dec     (dec),
    .ir      (ir),
    .alu_req (alu_req),
    .alu_res (alu_res),
    .wb      (wb),
    .acc     (acc),
    .status  (status)
  );

  cpu_decoder u_decoder (
    .ir  (ir),
    .dec (dec)
  );

  cpu_alu u_alu (
    .clk    (clk),
    .resetn (resetn),
    .req    (alu_req),
    .res    (alu_res)
  );

  cpu_regfile u_regfile (
    .clk    (clk),
    .resetn (resetn),
    .wb     (wb),
    .acc    (acc),
    .status (status)
  );

endmodule

/* tests/tb_cpu_top.sv */
//----------------------------------------------------------------------
// Runs an arithmetic program ending in a JMP loop, then one that halts
//----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_cpu_top
  import cpu_pkg::*;
();

  logic        clk;
  logic        resetn;
  logic [7:0]  rd_data;
  logic [15:0] address;
  logic [7:0]  wr_data;
  logic        wr_en;
  logic        sync;

  logic [7:0]  mem     [0:65535];   // Memory seen by the DUT
  logic [7:0]  ref_mem [0:65535];   // Private copy for the reference
  logic [15:0] exp_sync  [$];       // Expected opcode addresses
  logic [23:0] exp_store [$];       // Expected {address, data} stores
  logic [15:0] want_pc;
  logic [23:0] want_st;
  logic        loop_end;            // Program ends in a JMP to itself
  logic [15:0] loop_addr;
  logic [15:0] ptr;                 // Program build pointer
  logic [15:0] st_ptr;              // Next store address
  logic        checking;
  logic        timed_out;
  int          mismatches;
  int          others;
  int          cycles;
  int          start_cycle;
  int          limit;
  int          prog_bytes;

  cpu_top u_cpu_top (
    .clk     (clk),
    .resetn  (resetn),
    .rd_data (rd_data),
    .address (address),
    .wr_data (wr_data),
    .wr_en   (wr_en),
    .sync    (sync)
  );

  always #20 clk = ~clk;

  assign rd_data = mem[address];   // Combinational read

  always @(posedge clk) begin
    if (wr_en) mem[address] <= wr_data;
    cycles <= cycles + 1;
  end

  //----------------------------------------------------------------------
  // Comparison against the reference trace
  //----------------------------------------------------------------------
  always @(posedge clk) begin
    if (checking && resetn) begin
      if (sync) begin
        if (exp_sync.size() > 0) begin
          want_pc = exp_sync.pop_front();
          assert (address == want_pc) else begin
            mismatches++;
            $display("mismatch at %0t: opcode fetch exp %h got %h", $time, want_pc, address);
          end
        end else begin
          assert (loop_end && address == loop_addr) else begin
            others++;
            $display("Opcode fetch at %h after the program should have stopped", address);
          end
        end
      end
      if (wr_en) begin
        assert (exp_store.size() > 0) else begin
          others++;
          $display("Extra store of %h to %h that the program never makes", wr_data, address);
        end
        if (exp_store.size() > 0) begin
          want_st = exp_store.pop_front();
          assert ({address, wr_data} == want_st) else begin
            mismatches++;
            $display("mismatch at %0t: store exp %h<=%h got %h<=%h", $time,
                     want_st[23:8], want_st[7:0], address, wr_data);
          end
        end
      end
    end
  end

  //----------------------------------------------------------------------
  // Reference interpreter
  //----------------------------------------------------------------------
  function automatic void ref_run();
    logic [15:0] pc;
    logic [15:0] opnd;
    logic [7:0]  op;
    logic [7:0]  a;
    logic [7:0]  imm;
    logic [7:0]  absv;
    logic        c;
    int          steps;
    pc       = {ref_mem[16'hFFFD], ref_mem[16'hFFFC]};   // Little endian
    a        = 8'h00;
    c        = 1'b0;
    loop_end = 1'b0;
    for (steps = 0; steps < 4096; steps++) begin
      exp_sync.push_back(pc);
      op   = ref_mem[pc];
      opnd = {ref_mem[pc + 16'd2], ref_mem[pc + 16'd1]};
      imm  = ref_mem[pc + 16'd1];
      absv = ref_mem[opnd];
      case (op)
        LDA_IMM: a = imm;
        LDA_ABS: a = absv;
        ADC_IMM: {c, a} = {1'b0, a} + {1'b0, imm} + {8'd0, c};
        ADC_ABS: {c, a} = {1'b0, a} + {1'b0, absv} + {8'd0, c};
        AND_IMM: a = a & imm;
        AND_ABS: a = a & absv;
        ORA_IMM: a = a | imm;
        ORA_ABS: a = a | absv;
        STA_ABS: begin
          exp_store.push_back({opnd, a});
          ref_mem[opnd] = a;
        end
        JMP_ABS: begin
          if (opnd == pc) begin   // Self loop ends the trace after its first refetch
            exp_sync.push_back(pc);
            loop_end  = 1'b1;
            loop_addr = pc;
            return;
          end
        end
        NOP:     ;
        default: return;          // Illegal opcode, CPU halts
      endcase
      // Next opcode address
      case (op)
        NOP:                                pc = pc + 16'd1;
        LDA_IMM, ADC_IMM, AND_IMM, ORA_IMM: pc = pc + 16'd2;
        JMP_ABS:                            pc = opnd;
        default:                            pc = pc + 16'd3;
      endcase
    end
  endfunction

  //----------------------------------------------------------------------
  // Program builders
  //----------------------------------------------------------------------
  task automatic put_byte(input logic [7:0] b);
    mem[ptr] = b;
    ptr      = ptr + 16'd1;
    prog_bytes++;
  endtask

  task automatic put_imm(input logic [7:0] op, input logic [7:0] val);
    put_byte(op);
    put_byte(val);
  endtask

  task automatic put_abs(input logic [7:0] op, input logic [15:0] addr);
    put_byte(op);
    put_byte(addr[7:0]);
    put_byte(addr[15:8]);
  endtask

  task automatic put_store();
    put_abs(STA_ABS, st_ptr);
    st_ptr = st_ptr + 16'd1;
  endtask

  task automatic set_vector(input logic [15:0] start);
    mem[16'hFFFC] = start[7:0];
    mem[16'hFFFD] = start[15:8];
    ptr           = start;
    prog_bytes    = 0;
  endtask

  // Random data byte at a random address in 4000-4FFF
  task automatic put_data(output logic [15:0] addr);
    addr      = 16'h4000 | 16'($urandom & 32'h0FFF);
    mem[addr] = 8'($urandom);
  endtask

  task automatic build_arith();
    logic [15:0] d;
    logic [15:0] lp;
    set_vector(16'h0200 | 16'($urandom & 32'h0FF0));
    st_ptr = 16'h6000;
    put_byte(NOP);
    put_imm(LDA_IMM, 8'($urandom));
    put_store();
    put_data(d);
    put_abs(LDA_ABS, d);
    put_store();
    repeat (4) begin   // Carry chained through P
      put_imm(ADC_IMM, 8'($urandom));
      put_store();
      put_data(d);
      put_abs(ADC_ABS, d);
      put_store();
      put_imm(ADC_IMM, 8'h00);
      put_store();
    end
    put_imm(LDA_IMM, 8'hFF);   // Forces C to one ahead of the logical ops
    put_imm(ADC_IMM, 8'hFF);
    put_store();
    put_imm(AND_IMM, 8'($urandom));
    put_store();
    put_data(d);
    put_abs(AND_ABS, d);
    put_store();
    put_imm(ORA_IMM, 8'($urandom));
    put_store();
    put_data(d);
    put_abs(ORA_ABS, d);
    put_store();
    put_imm(ADC_IMM, 8'h00);   // C must survive AND and ORA
    put_store();
    put_abs(JMP_ABS, ptr + 16'd5);
    put_byte(8'h02);           // Skipped, would halt
    put_byte(8'h02);
    put_byte(NOP);
    lp = ptr;
    put_abs(JMP_ABS, lp);
  endtask

  task automatic build_halt();
    set_vector(16'h3000 | 16'($urandom & 32'h0FF0));
    put_imm(LDA_IMM, 8'($urandom));
    put_store();
    put_byte(NOP);
    put_byte(8'h02);   // Illegal
    put_store();       // Never reached
    put_store();
  endtask

  //----------------------------------------------------------------------
  // Reset, reference run and wait for the trace to drain
  //----------------------------------------------------------------------
  task automatic run_program(input logic expect_halt);
    @(negedge clk);
    checking = 1'b0;
    @(posedge clk);
    resetn <= 1'b0;
    @(negedge clk);
    ref_mem = mem;
    exp_sync.delete();
    exp_store.delete();
    ref_run();
    limit    = 6 * prog_bytes + 100;
    checking = 1'b1;
    repeat (2) @(posedge clk);
    resetn <= 1'b1;
    start_cycle = cycles;
    while ((exp_sync.size() > 0 || exp_store.size() > 0) && (cycles - start_cycle) < limit)
      @(posedge clk);
    if (exp_sync.size() > 0 || exp_store.size() > 0) begin
      timed_out = 1'b1;
      $display("Timeout after %0d cycles: %0d opcode fetches and %0d stores never happened",
               limit, exp_sync.size(), exp_store.size());
    end else if (expect_halt) begin
      while ((cycles - start_cycle) < limit) @(posedge clk);   // Must stay silent
    end else begin
      repeat (10) @(posedge clk);   // Loop keeps fetching the same JMP
    end
  endtask

  initial begin
    int i;
    void'($urandom(32'hb46c));
    clk        = 1'b0;
    resetn     = 1'b0;
    checking   = 1'b0;
    timed_out  = 1'b0;
    loop_end   = 1'b0;
    loop_addr  = 16'h0000;
    mismatches = 0;
    others     = 0;
    cycles     = 0;
    for (i = 0; i < 65536; i++) begin
      mem[i] = i[15:8] ^ {i[6:0], i[7]} ^ 8'h5A;   // Fill depends on every address bit
    end
    build_arith();
    run_program(1'b0);
    if (!timed_out) begin
      build_halt();
      run_program(1'b1);
    end
    $display("Errors: %0d mismatches, %0d other failures, timeout %0d",
             mismatches, others, timed_out);
    if (mismatches == 0 && others == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
verilog/cpu_pkg.sv
verilog/cpu_alu.sv
verilog/cpu_decoder.sv
verilog/cpu_regfile.sv
verilog/cpu_control.sv
verilog/cpu_top.sv
tests/tb_cpu_top.sv

/* Makefile */
# Verilator build and run of the 6502 subset testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
